// File: hw/pixbuf_pkg.sv
package pixbuf_pkg;

	// Bus side widths
	typedef logic [31:0] bus_addr_t;   // 68000 byte address
	typedef logic [15:0] bus_data_t;   // Upper and lower byte lanes

	// Buffer side widths
	typedef logic [7:0]  pix_byte_t;   // Eight vertically stacked pixels
	typedef logic [12:0] buf_addr_t;   // {frame column, row group}
	typedef logic [31:0] rgb_t;        // 0x00RRGGBB

	// Frame geometry, rotated arcade layout
	localparam int FRAME_COLS = 256;
	localparam int FRAME_ROWS = 256;
	localparam int COL_BITS = $clog2(FRAME_COLS);
	localparam int ROW_BITS = $clog2(FRAME_ROWS);
	localparam int ROW_GROUP_BITS = ROW_BITS - 3; // Eight rows per byte
	localparam int BUF_DEPTH = FRAME_COLS * FRAME_ROWS / 8;
	localparam int BUF_ADDR_BITS = $clog2(BUF_DEPTH);

	// Address bits 31..13 that select the buffer, base 0x0100_0000
	localparam logic [18:0] PIXBUF_WINDOW = 19'h00800;

	// Raster fields inside the video word address
	localparam int VID_X_LSB = 2;
	localparam int VID_X_BITS = 10;
	localparam int VID_Y_LSB = 12;
	localparam int VID_Y_BITS = 9;
	localparam int RASTER_WIDTH = 2 * FRAME_COLS; // 2x2 blocks
	localparam int RASTER_HEIGHT = 480;

	// Colour bands by frame row
	localparam int BAND_RED_END = 31;
	localparam int BAND_GREEN_START = 184;
	localparam int BAND_GREEN_END = 239;
	localparam rgb_t RGB_RED = 32'h00FF_0000;
	localparam rgb_t RGB_GREEN = 32'h0000_FF00;
	localparam rgb_t RGB_WHITE = 32'h00FF_FFFF;
	localparam rgb_t RGB_BLACK = 32'h0000_0000; // Unlit or off screen

	// Bus handshake states
	typedef enum logic [1:0] {IDLE, ACCESS, ACK} bus_state_t;

	// Tint for a lit pixel in a given frame row
	function automatic rgb_t band_colour(input logic [ROW_BITS-1:0] row);
		rgb_t colour;
		if (row <= BAND_RED_END)
			colour = RGB_RED; // Top strip
		else if (row >= BAND_GREEN_START && row <= BAND_GREEN_END)
			colour = RGB_GREEN;
		else
			colour = RGB_WHITE;
		return colour;
	endfunction

endpackage

// File: hw/cpu_bus_port.sv
`timescale 1ns/10ps

module cpu_bus_port (
	input  logic                  Clock25Mhz,
	input  logic                  rst,
	input  pixbuf_pkg::bus_addr_t address,
	input  logic                  as_l,
	input  logic                  uds_l,
	input  logic                  lds_l,
	input  logic                  rw,
	input  pixbuf_pkg::bus_data_t data_out,   // From the master
	output pixbuf_pkg::bus_data_t data_in,    // To the master
	output logic                  dtack_l,
	output pixbuf_pkg::buf_addr_t mem_addr,
	output logic                  mem_we,
	output pixbuf_pkg::pix_byte_t mem_wdata,
	input  pixbuf_pkg::pix_byte_t mem_rdata
);

	pixbuf_pkg::bus_state_t state;
	pixbuf_pkg::bus_state_t state_next;
	pixbuf_pkg::pix_byte_t  rd_byte;     // Held read byte for the lanes
	logic                   window_hit;
	logic                   selected;

	// Window decode on the top 19 address bits
	assign window_hit = (address[31:pixbuf_pkg::BUF_ADDR_BITS] == pixbuf_pkg::PIXBUF_WINDOW);
	assign selected = window_hit && !as_l;

	// Byte address straight from the bus, A0 included
	assign mem_addr = address[pixbuf_pkg::BUF_ADDR_BITS-1:0];
	assign mem_wdata = data_out[7:0]; // Low byte only, strobes ignored

	// Single write pulse on the edge that leaves IDLE
	assign mem_we = (state == pixbuf_pkg::IDLE) && selected && !rw;

	always_comb
	begin
		state_next = state;
		case (state)
			pixbuf_pkg::IDLE:
			begin
				if (selected)
					state_next = pixbuf_pkg::ACCESS;
			end
			pixbuf_pkg::ACCESS:
				state_next = pixbuf_pkg::ACK; // Memory byte is registered here
			pixbuf_pkg::ACK:
			begin
				// Hold until the master ends the cycle
				if (as_l)
					state_next = pixbuf_pkg::IDLE;
			end
			default:
				state_next = pixbuf_pkg::IDLE;
		endcase
	end

	always_ff @(posedge Clock25Mhz)
	begin
		if (rst)
			state <= pixbuf_pkg::IDLE;
		else
			state <= state_next;
	end

	// Port A output is valid one edge after the address, capture it in ACCESS
	always_ff @(posedge Clock25Mhz)
	begin
		if (state == pixbuf_pkg::ACCESS)
			rd_byte <= mem_rdata;
	end

	// Acknowledge falls one edge after ACK is reached, rises with as_l
	always_ff @(posedge Clock25Mhz)
	begin
		if (rst)
			dtack_l <= 1'b1;
		else
			dtack_l <= !((state == pixbuf_pkg::ACK) && !as_l);
	end

	// Lane steering, zero when no read is acknowledged
	always_comb
	begin
		data_in = '0;
		if (!dtack_l && rw)
		begin
			if (!uds_l)
				data_in[15:8] = rd_byte; // Even byte lane
			if (!lds_l)
				data_in[7:0] = rd_byte;  // Odd byte lane
		end
	end

	// Write pulse only on the first edge of a strobe, once per bus cycle
	assert property (@(posedge Clock25Mhz) disable iff (rst)
		mem_we |-> $past(as_l))
		else $error("mem_we without a fresh strobe, state %s", state.name());

	// Acknowledge has released once as_l has been high for two edges
	assert property (@(posedge Clock25Mhz) disable iff (rst)
		as_l ##1 as_l |-> dtack_l)
		else $error("dtack_l still low with as_l high, state %s", state.name());

endmodule

// File: hw/pixel_buffer_ram.sv
`timescale 1ns/10ps

module pixel_buffer_ram (
	input  logic                  Clock25Mhz,
	// Port A, processor side
	input  pixbuf_pkg::buf_addr_t a_addr,
	input  logic                  a_we,
	input  pixbuf_pkg::pix_byte_t a_wdata,
	output pixbuf_pkg::pix_byte_t a_rdata,
	// Port B, video side
	input  pixbuf_pkg::buf_addr_t b_addr,
	output pixbuf_pkg::pix_byte_t b_rdata
);

	// One byte per eight rows of a frame column
	pixbuf_pkg::pix_byte_t mem [pixbuf_pkg::BUF_DEPTH];

	// Port A is the only writer
	always_ff @(posedge Clock25Mhz)
	begin
		if (a_we)
			mem[a_addr] <= a_wdata;
	end

	// Registered read, old contents on a same-edge write
	always_ff @(posedge Clock25Mhz)
	begin
		a_rdata <= mem[a_addr];
	end

	// Video read, also read-first against port A writes
	always_ff @(posedge Clock25Mhz)
	begin
		b_rdata <= mem[b_addr]; // One cycle latency
	end

endmodule

// File: hw/midway_pixel_fetch.sv
`timescale 1ns/10ps

module midway_pixel_fetch (
	input  logic                  Clock25Mhz,
	input  logic                  rst,
	input  logic                  vid_read,
	input  pixbuf_pkg::bus_addr_t vid_address,
	output pixbuf_pkg::buf_addr_t mem_addr,
	input  pixbuf_pkg::pix_byte_t mem_rdata,
	output pixbuf_pkg::rgb_t      vid_readdata,
	output logic                  vid_readdatavalid
);

	logic [pixbuf_pkg::VID_X_BITS-1:0] raster_x;
	logic [pixbuf_pkg::VID_Y_BITS-1:0] raster_y;
	logic [pixbuf_pkg::COL_BITS-1:0]   frame_col;
	logic [pixbuf_pkg::ROW_BITS-1:0]   frame_row;
	logic                              off_screen;

	// Stage one registers, alongside the memory read
	logic                   valid_s1;
	logic                   off_screen_s1;
	logic [2:0]             bit_idx_s1;    // Row within the byte
	pixbuf_pkg::rgb_t       band_s1;
	logic                   lit;

	// Raster coordinates from the word address
	assign raster_x = vid_address[pixbuf_pkg::VID_X_LSB +: pixbuf_pkg::VID_X_BITS];
	assign raster_y = vid_address[pixbuf_pkg::VID_Y_LSB +: pixbuf_pkg::VID_Y_BITS];

	// Halve both axes for the 2x2 block
	assign frame_col = raster_x[pixbuf_pkg::COL_BITS:1];
	assign frame_row = raster_y[pixbuf_pkg::ROW_BITS:1];

	// Right of the frame or below the visible raster
	assign off_screen = (raster_x >= pixbuf_pkg::RASTER_WIDTH) ||
		(raster_y >= pixbuf_pkg::RASTER_HEIGHT);

	// Column times 32 plus row group
	assign mem_addr = {frame_col, frame_row[pixbuf_pkg::ROW_BITS-1 -: pixbuf_pkg::ROW_GROUP_BITS]};

	always_ff @(posedge Clock25Mhz)
	begin
		if (rst)
			valid_s1 <= 1'b0;
		else
			valid_s1 <= vid_read;
	end

	// Side data travels with the read, no reset needed on payload
	always_ff @(posedge Clock25Mhz)
	begin
		off_screen_s1 <= off_screen;
		bit_idx_s1 <= frame_row[2:0];
		band_s1 <= pixbuf_pkg::band_colour(frame_row); // Band by frame row
	end

	// Pixel bit out of the returned byte
	assign lit = mem_rdata[bit_idx_s1] && !off_screen_s1;

	always_ff @(posedge Clock25Mhz)
	begin
		if (rst)
			vid_readdatavalid <= 1'b0;
		else
			vid_readdatavalid <= valid_s1;
	end

	always_ff @(posedge Clock25Mhz)
	begin
		if (lit)
			vid_readdata <= band_s1;
		else
			vid_readdata <= pixbuf_pkg::RGB_BLACK; // Unlit pixel
	end

	// Fixed two-cycle pipeline, one response per request in order
	assert property (@(posedge Clock25Mhz) disable iff (rst)
		1'b1 |-> ##2 (vid_readdatavalid == $past(vid_read, 2)))
		else $error("vid_readdatavalid does not follow vid_read by two cycles");

endmodule

// File: hw/pixel_video_top.sv
`timescale 1ns/10ps

module pixel_video_top (
	input  logic                  Clock25Mhz,
	input  logic                  rst,
	// 68000 side
	input  pixbuf_pkg::bus_addr_t address,
	input  logic                  as_l,
	input  logic                  uds_l,
	input  logic                  lds_l,
	input  logic                  rw,
	input  pixbuf_pkg::bus_data_t data_out,
	output pixbuf_pkg::bus_data_t data_in,
	output logic                  dtack_l,
	// Video DMA side
	input  logic                  vid_read,
	input  pixbuf_pkg::bus_addr_t vid_address,
	output pixbuf_pkg::rgb_t      vid_readdata,
	output logic                  vid_readdatavalid
);

	pixbuf_pkg::buf_addr_t cpu_mem_addr;
	logic                  cpu_mem_we;
	pixbuf_pkg::pix_byte_t cpu_mem_wdata;
	pixbuf_pkg::pix_byte_t cpu_mem_rdata;
	pixbuf_pkg::buf_addr_t vid_mem_addr;
	pixbuf_pkg::pix_byte_t vid_mem_rdata;

	// Strobe handshake and lane steering
	cpu_bus_port i_cpu_bus_port (
		.Clock25Mhz (Clock25Mhz),
		.rst        (rst),
		.address    (address),
		.as_l       (as_l),
		.uds_l      (uds_l),
		.lds_l      (lds_l),
		.rw         (rw),
		.data_out   (data_out),
		.data_in    (data_in),
		.dtack_l    (dtack_l),
		.mem_addr   (cpu_mem_addr),
		.mem_we     (cpu_mem_we),
		.mem_wdata  (cpu_mem_wdata),
		.mem_rdata  (cpu_mem_rdata)
	);

	// Port A for the processor, port B for video
	pixel_buffer_ram i_pixel_buffer_ram (
		.Clock25Mhz (Clock25Mhz),
		.a_addr     (cpu_mem_addr),
		.a_we       (cpu_mem_we),
		.a_wdata    (cpu_mem_wdata),
		.a_rdata    (cpu_mem_rdata),
		.b_addr     (vid_mem_addr),
		.b_rdata    (vid_mem_rdata)
	);

	midway_pixel_fetch i_midway_pixel_fetch (
		.Clock25Mhz        (Clock25Mhz),
		.rst               (rst),
		.vid_read          (vid_read),
		.vid_address       (vid_address),
		.mem_addr          (vid_mem_addr),
		.mem_rdata         (vid_mem_rdata),
		.vid_readdata      (vid_readdata),
		.vid_readdatavalid (vid_readdatavalid)
	);

endmodule

// File: verification/tb_pixel_model.svh
`ifndef TB_PIXEL_MODEL_SVH
`define TB_PIXEL_MODEL_SVH

// Reference copy of the frame buffer, one byte per eight frame rows
pixbuf_pkg::pix_byte_t model_mem [8192];

// Print the reason and end the run
task automatic stop_run(input string why);
	$display("%s", why);
	$display("Errors found");
	$fatal(1, "Simulation stopped at the first error");
endtask

task automatic report_mismatch(input string msg);
	stop_run($sformatf("FAILED at %0t ns: %s", $time, msg));
endtask

// Tint of a lit pixel by frame row
function automatic pixbuf_pkg::rgb_t band_of_row(input int row);
	if (row <= pixbuf_pkg::BAND_RED_END)
		return 32'h00FF_0000; // Red strip at the top
	if (row >= pixbuf_pkg::BAND_GREEN_START && row <= pixbuf_pkg::BAND_GREEN_END)
		return 32'h0000_FF00;
	return 32'h00FF_FFFF;     // Everything else white
endfunction

// Pixel for a video word address, from the model contents
function automatic pixbuf_pkg::rgb_t expected_pixel(input pixbuf_pkg::bus_addr_t va);
	int x;
	int y;
	int col;
	int row;
	pixbuf_pkg::pix_byte_t b;
	x = int'((va >> pixbuf_pkg::VID_X_LSB) & ((32'd1 << pixbuf_pkg::VID_X_BITS) - 1));
	y = int'((va >> pixbuf_pkg::VID_Y_LSB) & ((32'd1 << pixbuf_pkg::VID_Y_BITS) - 1));
	if (x >= 512 || y >= 480)
		return '0; // Off the visible frame
	col = x / 2;   // 2x2 blocks
	row = y / 2;
	b = model_mem[col * 32 + row / 8];
	if (b[row % 8] == 1'b0)
		return '0;
	return band_of_row(row);
endfunction

// Byte copied onto each lane whose strobe is low
function automatic pixbuf_pkg::bus_data_t expected_lanes(input pixbuf_pkg::pix_byte_t b,
	input logic u, input logic l);
	pixbuf_pkg::bus_data_t d;
	d = '0;
	if (!u)
		d[15:8] = b;
	if (!l)
		d[7:0] = b;
	return d;
endfunction

task automatic check_bus_data(input pixbuf_pkg::bus_data_t got,
	input pixbuf_pkg::bus_data_t exp, input string what);
	if (got !== exp)
		report_mismatch($sformatf("%s: data_in %h, expected %h", what, got, exp));
endtask

task automatic check_pixel(input pixbuf_pkg::rgb_t got, input pixbuf_pkg::rgb_t exp);
	if (got !== exp)
		report_mismatch($sformatf("vid_readdata %h, expected %h", got, exp));
endtask

// Single control bits such as dtack_l or vid_readdatavalid
task automatic check_flag(input logic got, input logic exp, input string what);
	if (got !== exp)
		report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
endtask

// Watches dtack_l stay high for a bounded number of cycles
task automatic check_no_ack(input int cycles, input pixbuf_pkg::bus_addr_t a);
	for (int i = 0; i < cycles; i++)
	begin
		@(negedge Clock25Mhz);
		if (dtack_l !== 1'b1)
			report_mismatch($sformatf("dtack_l fell for address %h outside the window", a));
		check_bus_data(data_in, '0, "bus data outside the window");
	end
endtask

`endif

// File: verification/tb_pixel_video.sv
`timescale 1ns/10ps

module tb_pixel_video;

	localparam int HALF_PERIOD = 20;   // 40 ns clock
	localparam int TIMEOUT_CYCLES = 64;
	localparam int NO_ACK_CYCLES = 16;
	localparam int BUF_BYTES = 8192;

	logic                  Clock25Mhz;
	logic                  rst;
	pixbuf_pkg::bus_addr_t address;
	logic                  as_l;
	logic                  uds_l;
	logic                  lds_l;
	logic                  rw;
	pixbuf_pkg::bus_data_t data_out;
	pixbuf_pkg::bus_data_t data_in;
	logic                  dtack_l;
	logic                  vid_read;
	pixbuf_pkg::bus_addr_t vid_address;
	pixbuf_pkg::rgb_t      vid_readdata;
	logic                  vid_readdatavalid;
	logic [1:0]            read_hist;   // vid_read seen on the last two edges
	pixbuf_pkg::rgb_t      exp_q [$];   // Expected pixels in request order

	`include "tb_pixel_model.svh"

	pixel_video_top i_pixel_video_top (
		.Clock25Mhz        (Clock25Mhz),
		.rst               (rst),
		.address           (address),
		.as_l              (as_l),
		.uds_l             (uds_l),
		.lds_l             (lds_l),
		.rw                (rw),
		.data_out          (data_out),
		.data_in           (data_in),
		.dtack_l           (dtack_l),
		.vid_read          (vid_read),
		.vid_address       (vid_address),
		.vid_readdata      (vid_readdata),
		.vid_readdatavalid (vid_readdatavalid)
	);

	always #HALF_PERIOD Clock25Mhz = ~Clock25Mhz;

	function automatic pixbuf_pkg::bus_addr_t window_addr(input int byte_addr);
		return {pixbuf_pkg::PIXBUF_WINDOW, 13'(byte_addr)};
	endfunction

	// Polls dtack_l on falling edges until it reaches the given level
	task automatic wait_dtack(input logic level, input string what);
		int n;
		n = 0;
		do
		begin
			@(negedge Clock25Mhz);
			n++;
			if (n > TIMEOUT_CYCLES)
				stop_run($sformatf("Timed out waiting for dtack_l to go %0b in a %s", level, what));
		end
		while (dtack_l !== level);
	endtask

	// End of cycle, strobes up and wait for the acknowledge to drop
	task automatic release_bus();
		as_l = 1'b1;
		uds_l = 1'b1;
		lds_l = 1'b1;
		wait_dtack(1'b1, "bus release");
		check_bus_data(data_in, '0, "idle bus");
	endtask

	task automatic write_byte(input int byte_addr, input pixbuf_pkg::bus_data_t value);
		@(negedge Clock25Mhz);
		address = window_addr(byte_addr);
		rw = 1'b0;
		data_out = value;
		uds_l = 1'($urandom);   // Strobes do not gate the write
		lds_l = 1'($urandom);
		as_l = 1'b0;
		@(posedge Clock25Mhz);
		model_mem[byte_addr] = value[7:0]; // Edge that samples as_l low
		wait_dtack(1'b0, "write");
		release_bus();
	endtask

	task automatic read_byte(input int byte_addr);
		logic u;
		logic l;
		u = 1'($urandom);
		l = 1'($urandom);
		@(negedge Clock25Mhz);
		address = window_addr(byte_addr);
		rw = 1'b1;
		uds_l = u;
		lds_l = l;
		as_l = 1'b0;
		wait_dtack(1'b0, "read");
		check_bus_data(data_in, expected_lanes(model_mem[byte_addr], u, l),
			$sformatf("read of byte %h", byte_addr));
		release_bus();
	endtask

	// Access that misses the window, low address bits returned for readback
	task automatic outside_access(input bit is_write, output int low);
		pixbuf_pkg::bus_addr_t a;
		a = $urandom;
		if (a[31:13] == pixbuf_pkg::PIXBUF_WINDOW)
			a[31] = ~a[31]; // Nudge it out
		low = int'(a[12:0]);
		@(negedge Clock25Mhz);
		address = a;
		rw = !is_write;
		data_out = 16'($urandom);
		uds_l = 1'($urandom);
		lds_l = 1'($urandom);
		as_l = 1'b0;
		check_no_ack(NO_ACK_CYCLES, a);
		as_l = 1'b1;
		uds_l = 1'b1;
		lds_l = 1'b1;
	endtask

	function automatic pixbuf_pkg::bus_addr_t random_vid_address(input bit narrow);
		pixbuf_pkg::bus_addr_t va;
		int x;
		int y;
		va = $urandom; // Bits outside the fields are don't care
		if (narrow)
		begin
			x = $urandom % 4;   // Frame columns 0 and 1 only
			y = $urandom % 480;
		end
		else if ($urandom % 4 != 0)
		begin
			x = $urandom % 512;
			y = $urandom % 480;
		end
		else
		begin
			x = $urandom % 1024; // Mostly off screen
			y = $urandom % 512;
		end
		va[pixbuf_pkg::VID_X_LSB +: pixbuf_pkg::VID_X_BITS] = 10'(x);
		va[pixbuf_pkg::VID_Y_LSB +: pixbuf_pkg::VID_Y_BITS] = 9'(y);
		return va;
	endfunction

	task automatic video_burst(input int count, input bit narrow);
		for (int i = 0; i < count; i++)
		begin
			@(negedge Clock25Mhz);
			vid_read = ($urandom % 8 != 0); // Mostly back to back
			vid_address = random_vid_address(narrow);
			if (vid_read)
				exp_q.push_back(expected_pixel(vid_address));
		end
		@(negedge Clock25Mhz);
		vid_read = 1'b0;
	endtask

	task automatic wait_video_idle();
		int n;
		n = 0;
		do
		begin
			@(negedge Clock25Mhz);
			n++;
			if (n > TIMEOUT_CYCLES)
				stop_run("Timed out waiting for outstanding video reads to return");
		end
		while (exp_q.size() != 0);
	endtask

	always @(posedge Clock25Mhz)
	begin
		if (rst)
			read_hist <= 2'b00;
		else
			read_hist <= {read_hist[0], vid_read};
	end

	// Response monitor, valid timing and pixel value
	always @(negedge Clock25Mhz)
	begin
		if (!rst)
		begin
			check_flag(vid_readdatavalid, read_hist[1], "vid_readdatavalid");
			if (vid_readdatavalid === 1'b1)
			begin
				if (exp_q.size() == 0)
					stop_run("A video response arrived with no read outstanding");
				else
					check_pixel(vid_readdata, exp_q.pop_front());
			end
		end
	end

	initial
	begin
		int order [BUF_BYTES];
		int touched [$];
		int j;
		int t;
		int low;

		Clock25Mhz = 1'b0;
		rst = 1'b1;
		address = '0;
		as_l = 1'b1;
		uds_l = 1'b1;
		lds_l = 1'b1;
		rw = 1'b1;
		data_out = '0;
		vid_read = 1'b0;
		vid_address = '0;
		void'($urandom(32'h2b9d_e9bf));

		repeat (3) @(posedge Clock25Mhz);
		@(negedge Clock25Mhz);
		rst = 1'b0;
		check_flag(dtack_l, 1'b1, "dtack_l after reset");
		check_flag(vid_readdatavalid, 1'b0, "vid_readdatavalid after reset");
		check_bus_data(data_in, '0, "data_in after reset");

		// Every byte written once, in shuffled order
		for (int i = 0; i < BUF_BYTES; i++)
			order[i] = i;
		for (int i = BUF_BYTES - 1; i > 0; i--)
		begin
			j = $urandom % (i + 1);
			t = order[i];
			order[i] = order[j];
			order[j] = t;
		end
		foreach (order[i])
			write_byte(order[i], 16'($urandom));
		foreach (order[i])
			read_byte(order[i]); // Each byte back once, random strobes

		// Misses must leave the buffer alone
		for (int i = 0; i < 24; i++)
		begin
			outside_access(1'($urandom), low);
			touched.push_back(low);
		end
		foreach (touched[k])
			read_byte(touched[k]);

		video_burst(3000, 1'b0);
		wait_video_idle();

		// Same few bytes on both ports to hit same-edge collisions
		fork
			video_burst(4000, 1'b1);
			for (int i = 0; i < 300; i++)
				write_byte($urandom % 64, 16'($urandom));
		join
		wait_video_idle();

		$display("No errors");
		$finish;
	end

endmodule

// File: tb.f
+incdir+verification
hw/pixbuf_pkg.sv
hw/cpu_bus_port.sv
hw/pixel_buffer_ram.sv
hw/midway_pixel_fetch.sv
hw/pixel_video_top.sv
verification/tb_pixel_video.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the pixel buffer testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

TOP=tb_pixel_video
BUILD_DIR=obj_dir
LOG=sim.log

command -v verilator > /dev/null 2>&1
if [ $? -ne 0 ]; then
	echo "verilator was not found in PATH"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module "$TOP" -Mdir "$BUILD_DIR" -f tb.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
	echo "Simulation failed, see $LOG"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status, see $LOG"
	exit 1
fi

echo "Simulation passed"
exit 0
